//--- tb.f
+incdir+source
source/rack_node_pkg.sv
source/param_regs.sv
source/sim_tick_gen.sv
source/spike_synapse.sv
source/gain_stepper.sv
source/drive_mixer.sv
source/rack_node_top.sv
bench/tb_rack_node.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rack_node
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_rack_node.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module tb_rack_node;

    localparam int NUM_ROWS = 8;

    typedef struct packed {
        logic [31:0] div;      // divider, loaded through trigger bit 7
        logic [31:0] gain;     // sensory gain, loaded through trigger bit 13
        logic [3:0]  mask;     // spike lines used: extra2 extra1 ii ia
        logic [1:0]  toggles;  // button toggles per tick period
        logic [15:0] ticks;    // ticks to run
        logic [15:0] hold;     // sim reset cycles before the ticks
    } row_t;

    logic                    ep50trig;
    logic                    reset_global;
    logic                    i_sim_reset;
    logic [`TRIG_W-1:0]      i_trig;
    logic [`HALF_W-1:0]      i_wire_lo;
    logic [`HALF_W-1:0]      i_wire_hi;
    logic                    i_spike_ia;
    logic                    i_spike_ii;
    logic                    i_spike_extra1;
    logic                    i_spike_extra2;
    logic                    i_button;
    logic                    o_tick;
    rack_node_pkg::current_t o_drive;
    rack_node_pkg::scaler_t  o_scaler;

    row_t                    table_rows [NUM_ROWS];
    rack_node_pkg::current_t m_cur [4];   // ia, ii, extra1, extra2
    logic [3:0]              m_pend;
    rack_node_pkg::current_t m_drive;
    logic                    m_meta;
    logic                    m_sync;
    logic                    m_last;
    logic [3:0]              m_step;      // stepper count, scaler is its upper bits
    logic [31:0]             m_cnt;
    logic [31:0]             m_divq;      // divider of the running period
    logic [31:0]             m_div;
    logic [31:0]             m_gain;
    logic [31:0]             lcg_state;
    logic                    btn_level;
    logic                    tick_seen;
    int                      n_checks = 0;
    int                      n_errors = 0;
    int                      rows_ok = 0;
    int                      cycle_count = 0;
    int                      cycle_limit = 0;

    rack_node_top uut (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sim_reset    (i_sim_reset),
        .i_trig         (i_trig),
        .i_wire_lo      (i_wire_lo),
        .i_wire_hi      (i_wire_hi),
        .i_spike_ia     (i_spike_ia),
        .i_spike_ii     (i_spike_ii),
        .i_spike_extra1 (i_spike_extra1),
        .i_spike_extra2 (i_spike_extra2),
        .i_button       (i_button),
        .o_tick         (o_tick),
        .o_drive        (o_drive),
        .o_scaler       (o_scaler)
    );

    initial begin
        ep50trig = 1'b0;
        forever #4 ep50trig = ~ep50trig;  // 8 ns period
    end

    // watchdog on the fast clock
    always @(posedge ep50trig) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // cn drive as the node defines it, mod 2^32
    function automatic rack_node_pkg::current_t expected_mix(
        input rack_node_pkg::current_t ia, input rack_node_pkg::current_t ii,
        input rack_node_pkg::current_t e1, input rack_node_pkg::current_t e2,
        input logic [31:0] gain, input rack_node_pkg::scaler_t scaler);
        rack_node_pkg::current_t sense;
        rack_node_pkg::current_t cortical;
        sense    = (ia + ii) * gain;
        cortical = e2 * {29'd0, scaler};
        return (sense << `SENSE_SHIFT) + (cortical << `EXTRA_SHIFT) + (e1 << `EXTRA_SHIFT);
    endfunction

    // toggle slots at counts 1, 3 and 5 of a period
    function automatic logic toggle_due(input logic [1:0] toggles);
        return (toggles >= 2'd1 && m_cnt == 32'd1) || (toggles >= 2'd2 && m_cnt == 32'd3)
            || (toggles == 2'd3 && m_cnt == 32'd5);
    endfunction

    task automatic check_current(input string name, input rack_node_pkg::current_t got,
                                 input rack_node_pkg::current_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%0d expected=%0d",
                     $time, name, got, exp);
        end
    endtask

    task automatic check_scaler(input string name, input rack_node_pkg::scaler_t got,
                                input rack_node_pkg::scaler_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED time=%0t signal=%s got=%0d expected=%0d",
                     $time, name, got, exp);
        end
    endtask

    task automatic check_tick(input logic exp);
        n_checks++;
        if (o_tick !== exp) begin
            n_errors++;
            $display("tick period error at %0t: o_tick is %0b at count %0d of a %0d-cycle period",
                     $time, o_tick, m_cnt, m_divq + 32'd1);
        end
    endtask

    // advance the reference model across the coming clock edge
    task automatic update_model(input logic [3:0] spikes, input logic [`TRIG_W-1:0] trig,
                                input logic [31:0] word, input logic simrst, input logic tick);
        if (tick)  // mixer sees the currents before this edge
            m_drive = expected_mix(m_cur[0], m_cur[1], m_cur[2], m_cur[3], m_gain, m_step[3:1]);
        for (int i = 0; i < 4; i++) begin
            if (simrst) begin
                m_cur[i]  = '0;
                m_pend[i] = 1'b0;
            end else if (tick) begin
                m_cur[i]  = m_cur[i] - (m_cur[i] >> `SYN_DECAY_SHIFT)
                          + ((m_pend[i] || spikes[i]) ? `SYN_WEIGHT : 32'd0);
                m_pend[i] = 1'b0;
            end else if (spikes[i]) begin
                m_pend[i] = 1'b1;
            end
        end
        if (tick) begin
            if (m_sync != m_last)
                m_step = (m_step == `STEP_WRAP) ? 4'd0 : m_step + 4'd1;
            m_last = m_sync;
        end
        m_sync = m_meta;  // two-flop button path
        m_meta = btn_level;
        if (simrst || m_cnt == m_divq) begin
            m_cnt  = '0;
            m_divq = m_div;  // new divider only at a restart
        end else begin
            m_cnt = m_cnt + 32'd1;
        end
        if (trig[`TRIG_CLK_DIV])
            m_div = word;
        if (trig[`TRIG_SYN_GAIN])
            m_gain = word;
    endtask

    // drive at edge+1, check at edge+4, leave at the next edge+1
    task automatic run_cycle(input logic [3:0] spikes, input logic [`TRIG_W-1:0] trig,
                             input logic [31:0] word, input logic simrst);
        logic exp_tick;
        i_spike_ia     = spikes[0];
        i_spike_ii     = spikes[1];
        i_spike_extra1 = spikes[2];
        i_spike_extra2 = spikes[3];
        i_button       = btn_level;
        i_trig         = trig;
        i_wire_hi      = word[31:16];
        i_wire_lo      = word[15:0];
        i_sim_reset    = simrst;
        #3;
        exp_tick = (m_cnt == m_divq) && !simrst;
        check_current("o_drive", o_drive, m_drive);
        check_scaler("o_scaler", o_scaler, m_step[3:1]);
        check_tick(exp_tick);
        tick_seen = o_tick;
        update_model(spikes, trig, word, simrst, exp_tick);
        @(posedge ep50trig);
        #1;
    endtask

    task automatic run_row(input int idx);
        row_t       r;
        int         ticks_seen;
        int         err_before;
        int         chk_before;
        logic [3:0] spikes;
        r          = table_rows[idx];
        ticks_seen = 0;
        err_before = n_errors;
        chk_before = n_checks;
        run_cycle(4'b0, 16'd1 << `TRIG_CLK_DIV, r.div, 1'b0);
        run_cycle(4'b0, 16'd1 << `TRIG_SYN_GAIN, r.gain, 1'b0);
        run_cycle(4'b0, '0, 32'd0, 1'b0);  // wires back to idle
        repeat (r.hold) run_cycle(4'b0, '0, 32'd0, 1'b1);
        while (ticks_seen < int'(r.ticks)) begin
            lcg_state = lcg_next(lcg_state);
            for (int i = 0; i < 4; i++)
                spikes[i] = r.mask[i] && (lcg_state[8 + 4 * i +: 4] == 4'd0);  // about 1 in 16
            if (toggle_due(r.toggles))
                btn_level = ~btn_level;
            run_cycle(spikes, '0, 32'd0, 1'b0);
            if (tick_seen)
                ticks_seen++;
        end
        if (n_errors == err_before)
            rows_ok++;
        $display("test %0d: %s, %0d checks, %0d errors", idx,
                 (n_errors == err_before) ? "ok" : "mismatch",
                 n_checks - chk_before, n_errors - err_before);
    endtask

    initial begin
        reset_global   = 1'b1;
        i_sim_reset    = 1'b0;
        i_trig         = '0;
        i_wire_lo      = '0;
        i_wire_hi      = '0;
        i_spike_ia     = 1'b0;
        i_spike_ii     = 1'b0;
        i_spike_extra1 = 1'b0;
        i_spike_extra2 = 1'b0;
        i_button       = 1'b0;
        btn_level      = 1'b0;
        tick_seen      = 1'b0;
        lcg_state      = 32'h5df725f5;
        // div, gain, mask, toggles, ticks, hold
        table_rows[0] = '{32'd381, 32'd1, 4'h0, 2'd0, 16'd3, 16'd0};         // reset timing
        table_rows[1] = '{32'd9, 32'd1, 4'hF, 2'd0, 16'd12, 16'd0};          // divider load
        table_rows[2] = '{32'd14, 32'h0002_0005, 4'hF, 2'd0, 16'd25, 16'd0}; // gain hi half
        table_rows[3] = '{32'd9, 32'd3, 4'hF, 2'd1, 16'd40, 16'd0};          // stepper wraps
        table_rows[4] = '{32'd9, 32'd2, 4'hF, 2'd3, 16'd20, 16'd0};          // 3 toggles per tick
        table_rows[5] = '{32'd9, 32'd2, 4'hA, 2'd2, 16'd10, 16'd0};          // level returns
        table_rows[6] = '{32'd9, 32'd3, 4'h0, 2'd0, 16'd6, 16'd30};          // sim reset
        table_rows[7] = '{32'd9, 32'd1, 4'h5, 2'd1, 16'd15, 16'd0};          // spikes again
        cycle_limit = 10 + 1000;  // reset plus margin for the old 382-cycle period
        for (int k = 0; k < NUM_ROWS; k++)
            cycle_limit += int'(table_rows[k].div + 32'd1) * int'(table_rows[k].ticks)
                         + int'(table_rows[k].hold) + 3;
        for (int i = 0; i < 4; i++)
            m_cur[i] = '0;
        m_pend  = '0;
        m_drive = '0;
        m_meta  = 1'b0;
        m_sync  = 1'b0;
        m_last  = 1'b0;
        m_step  = '0;
        m_cnt   = '0;
        m_divq  = `DIV_RESET;
        m_div   = `DIV_RESET;
        m_gain  = `GAIN_RESET;
        repeat (10) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;
        for (int k = 0; k < NUM_ROWS; k++)
            run_row(k);
        $display("summary: %0d of %0d tests clean, %0d checks, %0d errors",
                 rows_ok, NUM_ROWS, n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/rack_node_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module rack_node_top (
    input  wire                     ep50trig,
    input  wire                     reset_global,
    input  wire                     i_sim_reset,
    input  wire [`TRIG_W-1:0]       i_trig,
    input  wire [`HALF_W-1:0]       i_wire_lo,
    input  wire [`HALF_W-1:0]       i_wire_hi,
    input  wire                     i_spike_ia,      // Ia afferent
    input  wire                     i_spike_ii,      // II afferent
    input  wire                     i_spike_extra1,  // cortical extra 1
    input  wire                     i_spike_extra2,  // cortical extra 2, button scaled
    input  wire                     i_button,
    output logic                    o_tick,
    output rack_node_pkg::current_t o_drive,
    output rack_node_pkg::scaler_t  o_scaler
);

    rack_node_pkg::param_word_u clk_div;
    rack_node_pkg::param_word_u syn_gain;

    rack_node_pkg::current_t cur_ia;
    rack_node_pkg::current_t cur_ii;
    rack_node_pkg::current_t cur_extra1;
    rack_node_pkg::current_t cur_extra2;

    param_regs u_param_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .o_clk_div    (clk_div),
        .o_syn_gain   (syn_gain)
    );

    sim_tick_gen u_sim_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_clk_div    (clk_div),
        .o_tick       (o_tick)          // also the step strobe for the blocks below
    );

    spike_synapse syn_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_tick       (o_tick),
        .i_spike      (i_spike_ia),
        .o_current    (cur_ia)
    );

    spike_synapse syn_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_tick       (o_tick),
        .i_spike      (i_spike_ii),
        .o_current    (cur_ii)
    );

    spike_synapse syn_extra1 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_tick       (o_tick),
        .i_spike      (i_spike_extra1),
        .o_current    (cur_extra1)
    );

    spike_synapse syn_extra2 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_tick       (o_tick),
        .i_spike      (i_spike_extra2),
        .o_current    (cur_extra2)
    );

    gain_stepper u_gain_stepper (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (o_tick),
        .i_button     (i_button),
        .o_scaler     (o_scaler)
    );

    drive_mixer u_drive_mixer (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (o_tick),
        .i_cur_ia     (cur_ia),
        .i_cur_ii     (cur_ii),
        .i_cur_extra1 (cur_extra1),
        .i_cur_extra2 (cur_extra2),
        .i_syn_gain   (syn_gain),
        .i_scaler     (o_scaler),
        .o_drive      (o_drive)
    );

endmodule

`default_nettype wire

//--- source/drive_mixer.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module drive_mixer (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire                        i_tick,
    input  rack_node_pkg::current_t    i_cur_ia,
    input  rack_node_pkg::current_t    i_cur_ii,
    input  rack_node_pkg::current_t    i_cur_extra1,
    input  rack_node_pkg::current_t    i_cur_extra2,
    input  rack_node_pkg::param_word_u i_syn_gain,  // integer gain for Ia + II
    input  rack_node_pkg::scaler_t     i_scaler,    // button scaler for extra2
    output rack_node_pkg::current_t    o_drive      // cn drive, held between ticks
);

    localparam int SCALER_PAD = `WORD_W - $bits(rack_node_pkg::scaler_t);

    rack_node_pkg::current_t sense_sum;      // Ia + II
    rack_node_pkg::current_t sense_gained;
    rack_node_pkg::current_t scaler_word;
    rack_node_pkg::current_t extra2_scaled;
    rack_node_pkg::current_t mix;

    assign sense_sum     = i_cur_ia + i_cur_ii;
    assign sense_gained  = sense_sum * i_syn_gain.value;    // wraps mod 2^32
    assign scaler_word   = {{SCALER_PAD{1'b0}}, i_scaler};
    assign extra2_scaled = i_cur_extra2 * scaler_word;

    // sensory term gets the smaller shift, cortical terms share the larger one
    assign mix = (sense_gained << `SENSE_SHIFT)
               + (extra2_scaled << `EXTRA_SHIFT)
               + (i_cur_extra1 << `EXTRA_SHIFT);

    // latch once per step, the synapses update on the same edge
    // so the drive carries the previous step's currents
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global)
            o_drive <= '0;
        else if (i_tick)
            o_drive <= mix;
    end

endmodule

`default_nettype wire

//--- source/gain_stepper.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module gain_stepper (
    input  wire                    ep50trig,
    input  wire                    reset_global,
    input  wire                    i_tick,
    input  wire                    i_button,   // asynchronous button level
    output rack_node_pkg::scaler_t o_scaler
);

    logic       btn_meta;    // first sync stage
    logic       btn_sync;    // second sync stage, safe to use
    logic       btn_last;    // level seen at the previous tick
    logic       btn_moved;
    logic [3:0] step_cnt;    // 0 .. STEP_WRAP

    // two-flop synchronizer
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= i_button;
            btn_sync <= btn_meta;
        end
    end

    // level change since the last tick, so several toggles count once
    assign btn_moved = btn_sync ^ btn_last;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_last <= 1'b0;
            step_cnt <= '0;
        end else if (i_tick) begin
            btn_last <= btn_sync;
            if (btn_moved) begin
                if (step_cnt == `STEP_WRAP)
                    step_cnt <= '0;            // 7 -> 0 on the scaler
                else
                    step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    assign o_scaler = step_cnt[3:1];  // two presses per scaler step

    a_cnt_range : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        step_cnt <= `STEP_WRAP
    ) else $error("gain_stepper: count beyond wrap point");

endmodule

`default_nettype wire

//--- source/spike_synapse.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module spike_synapse (
    input  wire                     ep50trig,
    input  wire                     reset_global,
    input  wire                     i_sim_reset,
    input  wire                     i_tick,
    input  wire                     i_spike,     // raw spike line from another board
    output rack_node_pkg::current_t o_current
);

    logic                     spike_pend;  // spike seen since the last tick
    logic                     spike_hit;   // spike counts for this tick
    rack_node_pkg::current_t  cur_decayed;
    rack_node_pkg::current_t  cur_next;

    assign spike_hit   = spike_pend | i_spike;              // same-cycle spike counts too
    assign cur_decayed = o_current - (o_current >> `SYN_DECAY_SHIFT);
    assign cur_next    = cur_decayed + (spike_hit ? `SYN_WEIGHT : '0);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            spike_pend <= 1'b0;
            o_current  <= '0;
        end else if (i_sim_reset) begin
            spike_pend <= 1'b0;
            o_current  <= '0;
        end else if (i_tick) begin
            spike_pend <= 1'b0;        // consumed
            o_current  <= cur_next;    // one step of exponential decay
        end else if (i_spike) begin
            spike_pend <= 1'b1;
        end
    end

    // decay balances one spike per tick at weight << shift
    a_cur_bound : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_current <= (`SYN_WEIGHT << `SYN_DECAY_SHIFT)
    ) else $error("spike_synapse: current above the decay fixed point");

endmodule

`default_nettype wire

//--- source/sim_tick_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module sim_tick_gen (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire                        i_sim_reset,  // level, holds the counter at 0
    input  rack_node_pkg::param_word_u i_clk_div,
    output logic                       o_tick        // 1 ms simulation step strobe
);

    logic [`WORD_W-1:0] tick_cnt;   // 0 .. div_q
    logic [`WORD_W-1:0] div_q;      // divider in use for this period
    logic               at_end;

    assign at_end = (tick_cnt == div_q);
    assign o_tick = at_end & ~i_sim_reset;  // no steps while the sim is held

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            tick_cnt <= '0;
            div_q    <= `DIV_RESET;
        end else if (i_sim_reset || at_end) begin
            tick_cnt <= '0;                 // restart
            div_q    <= i_clk_div.value;    // new divider applies from here on
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // after a tick the next period is at least two cycles long
    a_tick_single : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_tick && (i_clk_div.value != '0)) |=> !o_tick
    ) else $error("sim_tick_gen: tick held high for two cycles");

endmodule

`default_nettype wire

//--- source/param_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "rack_node_defs.svh"

module param_regs (
    input  wire                        ep50trig,
    input  wire                        reset_global,
    input  wire [`TRIG_W-1:0]          i_trig,      // one-cycle trigger pulses
    input  wire [`HALF_W-1:0]          i_wire_lo,   // endpoint 01
    input  wire [`HALF_W-1:0]          i_wire_hi,   // endpoint 02
    output rack_node_pkg::param_word_u o_clk_div,
    output rack_node_pkg::param_word_u o_syn_gain
);

    rack_node_pkg::param_word_u load_word;  // word the host is holding

    // place the endpoints straight into the halves view
    always_comb begin
        load_word.halves.hi = i_wire_hi;
        load_word.halves.lo = i_wire_lo;
    end

    // tick divider, bit 7
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_clk_div.value <= `DIV_RESET;     // real-time speed
        end else if (i_trig[`TRIG_CLK_DIV]) begin
            o_clk_div <= load_word;
        end
    end

    // sensory gain, bit 13
    // host may pulse both bits together, each register then takes the same word
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_syn_gain.value <= `GAIN_RESET;
        end else if (i_trig[`TRIG_SYN_GAIN]) begin
            o_syn_gain <= load_word;
        end
    end

    // a zero divider would make the tick a constant level and stall the synapses
    a_div_nonzero : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_trig[`TRIG_CLK_DIV] |=> (o_clk_div.value != '0)
    ) else $error("param_regs: divider loaded with 0");

endmodule

`default_nettype wire

//--- source/rack_node_pkg.sv
`default_nettype none

`include "rack_node_defs.svh"

package rack_node_pkg;

    // one word from the host, either as the two endpoint halves or as a number
    typedef union packed {
        struct packed {
            logic [`HALF_W-1:0] hi;   // endpoint 02
            logic [`HALF_W-1:0] lo;   // endpoint 01
        } halves;
        logic [`WORD_W-1:0] value;    // unsigned integer view
    } param_word_u;

    // synaptic current or cn drive, plain unsigned integer
    typedef logic [`WORD_W-1:0] current_t;

    // button scaler 0..7
    typedef logic [2:0] scaler_t;

endpackage

`default_nettype wire

//--- source/rack_node_defs.svh
`ifndef RACK_NODE_DEFS_SVH
`define RACK_NODE_DEFS_SVH

// datapath widths
`define WORD_W          32      // parameter words, currents, drive
`define HALF_W          16      // one wire endpoint
`define TRIG_W          16      // trigger endpoint bits

// trigger bit map, other bits are not decoded on this node
`define TRIG_CLK_DIV    7       // tick divider
`define TRIG_SYN_GAIN   13      // sensory synapse gain

// register defaults after reset_global
`define DIV_RESET       32'd381 // 382 fast cycles per 1 ms step
`define GAIN_RESET      32'd1   // unity sensory gain

// simple synapse
`define SYN_WEIGHT      32'd1024 // current kick per spike
`define SYN_DECAY_SHIFT 3        // lose 1/8 of the current per tick

// drive mixer shifts
`define SENSE_SHIFT     9       // Ia + II term
`define EXTRA_SHIFT     10      // cortical extra terms

// push-button stepper
`define STEP_WRAP       4'd14   // last count before wrap, scaler 7

`endif
